//--- sw_config.svh
`ifndef SW_CONFIG_SVH
`define SW_CONFIG_SVH

// array geometry
// one PE per query base, so this is also the query length
`define SW_N_PE 16

// signed score word, wide enough for N_PE matches plus the X-drop margin
`define SW_SCORE_W 14

// reference position counter width
`define SW_POS_W 10

// substitution scores
`define SW_MATCH 2
// subtracted on a mismatch
`define SW_MISMATCH 1

// affine gap costs
// first gap position costs GAP_OPEN, each further one GAP_EXT
`define SW_GAP_OPEN 12
`define SW_GAP_EXT 1

// early stop once the wavefront max falls this far below the best
`define SW_XDROP 40

`endif

//--- sw_score_pkg.sv
`include "sw_config.svh"

package sw_score_pkg;

    // nucleotide code, A=0 C=1 G=2 T=3
    typedef logic [1:0] base_t;

    // cell score, two's complement
    typedef logic signed [`SW_SCORE_W-1:0] score_t;

    // what PE k hands to PE k+1 for one reference column
    typedef struct packed {
        base_t  base;
        score_t h;
        score_t f;
        logic   valid;
    } pe_link_t;

    // position of a PE inside the array, i.e. the query index
    typedef logic [$clog2(`SW_N_PE)-1:0] qidx_t;

endpackage

//--- sw_ctrl_pkg.sv
`include "sw_config.svh"

package sw_ctrl_pkg;

    import sw_score_pkg::*;

    // aligner sequencing
    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        DRAIN,
        DONE
    } align_state_t;

    // best local alignment end point
    typedef struct packed {
        score_t                score;
        logic [`SW_POS_W-1:0]  ref_pos;
        qidx_t                 qry_pos;
    } align_result_t;

endpackage

//--- sw_pe.sv
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_pe
    import sw_score_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_clear,
    input  base_t    i_query_base,
    input  pe_link_t i_link,
    output pe_link_t o_link,
    output score_t   o_h,
    output logic     o_valid
);

    localparam score_t MATCH    = score_t'(`SW_MATCH);
    localparam score_t MISS     = -score_t'(`SW_MISMATCH);
    localparam score_t GAP_OPEN = score_t'(`SW_GAP_OPEN);
    localparam score_t GAP_EXT  = score_t'(`SW_GAP_EXT);

    // cell state, H and E of the previous column and the diagonal H
    score_t h_q;
    score_t e_q;
    score_t f_q;
    score_t diag_q;
    base_t  base_q;
    logic   valid_q;

    score_t sub;
    score_t e_new;
    score_t f_new;
    score_t h_new;

    function automatic score_t smax(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

    // Gotoh recurrence, E runs along the reference, F along the query
    always_comb begin
        sub   = (i_link.base == i_query_base) ? MATCH : MISS;
        e_new = smax(h_q - GAP_OPEN, e_q - GAP_EXT);
        f_new = smax(i_link.h - GAP_OPEN, i_link.f - GAP_EXT);
        // local alignment, never below zero
        h_new = smax(smax(diag_q + sub, score_t'(0)), smax(e_new, f_new));
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (i_clear) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_link.valid;
        end
    end

    // scores only move on a real column, bubbles leave them alone
    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            h_q    <= '0;
            e_q    <= '0;
            f_q    <= '0;
            diag_q <= '0;
        end else if (i_link.valid) begin
            h_q    <= h_new;
            e_q    <= e_new;
            f_q    <= f_new;
            diag_q <= i_link.h;
            base_q <= i_link.base;
        end
    end

    always_comb begin
        o_link.base  = base_q;
        o_link.h     = h_q;
        o_link.f     = f_q;
        o_link.valid = valid_q;
    end

    assign o_h     = h_q;
    assign o_valid = valid_q;

endmodule

//--- sw_pe_array.sv
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_pe_array
    import sw_score_pkg::*;
#(
    parameter int N_PE = `SW_N_PE
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_clear,
    input  logic                i_load,
    input  base_t  [N_PE-1:0]   i_query,
    input  logic                i_shift,
    input  base_t               i_ref_base,
    output score_t [N_PE-1:0]   o_h_vec,
    output logic   [N_PE-1:0]   o_valid_vec
);

    // query bases, one per PE, held for the whole alignment
    base_t [N_PE-1:0] query_q;

    // link[k] feeds PE k, link[N_PE] falls off the end of the array
    pe_link_t [N_PE:0] link;

    score_t [N_PE-1:0] h_raw;

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            query_q <= i_query;
        end
    end

    // head of the chain
    // the virtual row above the query has H and F of zero
    always_comb begin
        link[0].base  = i_ref_base;
        link[0].h     = '0;
        link[0].f     = '0;
        link[0].valid = i_shift;
    end

    for (genvar k = 0; k < N_PE; k++) begin : g_pe
        sw_pe u_pe (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_clear      (i_clear),
            .i_query_base (query_q[k]),
            .i_link       (link[k]),
            .o_link       (link[k+1]),
            .o_h          (h_raw[k]),
            .o_valid      (o_valid_vec[k])
        );

        // idle PEs count as zero in the wavefront max
        assign o_h_vec[k] = o_valid_vec[k] ? h_raw[k] : '0;
    end

endmodule

//--- sw_max_tree.sv
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_max_tree
    import sw_score_pkg::*;
#(
    parameter int N_PE = `SW_N_PE
) (
    input  score_t [N_PE-1:0] i_h_vec,
    output score_t            o_max,
    output qidx_t             o_idx
);

    localparam int LVL = (N_PE > 1) ? $clog2(N_PE) : 1;
    // leaves padded up to a power of two
    localparam int NP  = 1 << LVL;

    score_t val [0:LVL][0:NP-1];
    qidx_t  idx [0:LVL][0:NP-1];

    always_comb begin
        for (int n = 0; n < NP; n++) begin
            if (n < N_PE) begin
                val[0][n] = i_h_vec[n];
            end else begin
                val[0][n] = '0;
            end
            idx[0][n] = qidx_t'(n);
        end

        // left child always holds the lower indices, so it keeps ties
        for (int l = 0; l < LVL; l++) begin
            for (int n = 0; n < NP / 2; n++) begin
                if (n < (NP >> (l + 1))) begin
                    if (val[l][2*n+1] > val[l][2*n]) begin
                        val[l+1][n] = val[l][2*n+1];
                        idx[l+1][n] = idx[l][2*n+1];
                    end else begin
                        val[l+1][n] = val[l][2*n];
                        idx[l+1][n] = idx[l][2*n];
                    end
                end else begin
                    val[l+1][n] = '0;
                    idx[l+1][n] = '0;
                end
            end
            // upper half of each level is never used
            for (int n = NP / 2; n < NP; n++) begin
                val[l+1][n] = '0;
                idx[l+1][n] = '0;
            end
        end
    end

    assign o_max = val[LVL][0];
    assign o_idx = idx[LVL][0];

endmodule

//--- sw_align_ctrl.sv
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_align_ctrl
    import sw_score_pkg::*;
    import sw_ctrl_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_start,
    input  logic          i_ref_valid,
    input  logic          i_ref_last,
    output logic          o_ref_ready,
    output logic          o_shift,
    output logic          o_clear,
    output logic          o_load,
    input  logic          i_any_valid,
    input  score_t        i_wave_max,
    input  qidx_t         i_wave_idx,
    output logic          o_done,
    output align_result_t o_result
);

    localparam score_t XDROP = score_t'(`SW_XDROP);
    localparam logic [`SW_POS_W-1:0] MIN_BASES = `SW_POS_W'(`SW_N_PE);
    localparam qidx_t LAST_PE = qidx_t'(`SW_N_PE - 1);

    align_state_t         state;
    logic [`SW_POS_W-1:0] base_cnt;
    qidx_t                drain_cnt;
    // set once X-drop fired, the array is being flushed
    logic                 flush;
    logic                 done_q;
    align_result_t        result_q;

    // column number of the cell each PE currently shows
    logic [`SW_POS_W-1:0] col_pipe [0:`SW_N_PE-1];

    logic start_acc;
    logic xfer;
    logic scoring;
    logic xdrop_hit;
    logic better;

    assign start_acc = i_start && (state == IDLE || state == DONE);
    assign xfer      = i_ref_valid && o_ref_ready;
    assign scoring   = (state == STREAM) || (state == DRAIN && !flush);

    // wavefront fell too far below the running best
    assign xdrop_hit = scoring && i_any_valid && (base_cnt >= MIN_BASES) &&
                       (score_t'(i_wave_max + XDROP) < result_q.score);

    // strictly greater, so the first occurrence is kept
    assign better = scoring && i_any_valid && (i_wave_max > result_q.score);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state     <= IDLE;
            base_cnt  <= '0;
            drain_cnt <= '0;
            flush     <= 1'b0;
            done_q    <= 1'b0;
            result_q  <= '0;
        end else begin
            done_q <= 1'b0;

            if (better) begin
                result_q.score   <= i_wave_max;
                result_q.ref_pos <= col_pipe[i_wave_idx];
                result_q.qry_pos <= i_wave_idx;
            end

            case (state)
                IDLE, DONE: begin
                    if (start_acc) begin
                        state     <= STREAM;
                        base_cnt  <= '0;
                        drain_cnt <= '0;
                        flush     <= 1'b0;
                        result_q  <= '0;
                    end
                end
                STREAM: begin
                    if (xfer) begin
                        base_cnt <= base_cnt + 1'b1;
                    end
                    if (xdrop_hit) begin
                        state <= DRAIN;
                        flush <= 1'b1;
                    end else if (xfer && i_ref_last) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    if (flush) begin
                        state  <= DONE;
                        done_q <= 1'b1;
                    end else if (xdrop_hit) begin
                        flush <= 1'b1;
                    end else if (drain_cnt == LAST_PE) begin
                        // last column has left the final PE
                        state  <= DONE;
                        done_q <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // follows the array one PE per cycle, bubbles included
    always_ff @(posedge i_clk) begin
        col_pipe[0] <= base_cnt;
        for (int k = 1; k < `SW_N_PE; k++) begin
            col_pipe[k] <= col_pipe[k-1];
        end
    end

    assign o_ref_ready = (state == STREAM);
    assign o_shift     = xfer;
    assign o_load      = start_acc;
    // start wipes the old alignment, a flush drops work in flight
    assign o_clear     = start_acc || (state == DRAIN && flush);
    assign o_done      = done_q;
    assign o_result    = result_q;

endmodule

//--- sw_aligner_top.sv
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_aligner_top
    import sw_score_pkg::*;
    import sw_ctrl_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_start,
    input  base_t [`SW_N_PE-1:0] i_query,
    input  logic                 i_ref_valid,
    input  base_t                i_ref_base,
    input  logic                 i_ref_last,
    output logic                 o_ref_ready,
    output logic                 o_done,
    output align_result_t        o_result
);

    logic shift;
    logic clear;
    logic load;

    score_t [`SW_N_PE-1:0] h_vec;
    logic   [`SW_N_PE-1:0] valid_vec;
    score_t                wave_max;
    qidx_t                 wave_idx;

    sw_align_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_ref_valid (i_ref_valid),
        .i_ref_last  (i_ref_last),
        .o_ref_ready (o_ref_ready),
        .o_shift     (shift),
        .o_clear     (clear),
        .o_load      (load),
        .i_any_valid (|valid_vec),
        .i_wave_max  (wave_max),
        .i_wave_idx  (wave_idx),
        .o_done      (o_done),
        .o_result    (o_result)
    );

    sw_pe_array #(
        .N_PE (`SW_N_PE)
    ) u_array (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_clear     (clear),
        .i_load      (load),
        .i_query     (i_query),
        .i_shift     (shift),
        .i_ref_base  (i_ref_base),
        .o_h_vec     (h_vec),
        .o_valid_vec (valid_vec)
    );

    sw_max_tree #(
        .N_PE (`SW_N_PE)
    ) u_tree (
        .i_h_vec (h_vec),
        .o_max   (wave_max),
        .o_idx   (wave_idx)
    );

endmodule

//--- sw_monitor.sv
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_monitor
    import sw_score_pkg::*;
    import sw_ctrl_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_done,
    input  align_result_t i_result,
    input  align_result_t i_exp,
    input  int            i_exp_cnt,
    output int            o_err_cnt,
    output int            o_chk_cnt
);

    initial begin
        o_err_cnt = 0;
        o_chk_cnt = 0;
    end

    // result is registered, so the falling edge sees it settled
    always @(negedge i_clk) begin
        if (i_done) begin
            if (o_chk_cnt >= i_exp_cnt) begin
                $display("done pulse at %0t with no expected result posted", $time);
                o_err_cnt = o_err_cnt + 1;
            end else begin
                if (i_result.score !== i_exp.score) begin
                    $display("MISMATCH t=%0t score exp=%0d got=%0d",
                             $time, i_exp.score, i_result.score);
                    o_err_cnt = o_err_cnt + 1;
                end
                if (i_result.ref_pos !== i_exp.ref_pos) begin
                    $display("MISMATCH t=%0t ref_pos exp=%0d got=%0d",
                             $time, i_exp.ref_pos, i_result.ref_pos);
                    o_err_cnt = o_err_cnt + 1;
                end
                if (i_result.qry_pos !== i_exp.qry_pos) begin
                    $display("MISMATCH t=%0t qry_pos exp=%0d got=%0d",
                             $time, i_exp.qry_pos, i_result.qry_pos);
                    o_err_cnt = o_err_cnt + 1;
                end
            end
            o_chk_cnt = o_chk_cnt + 1;
        end
    end

endmodule

//--- sw_aligner_chk.sv
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_aligner_chk (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_start,
    input  logic i_shift,
    input  logic i_ref_last,
    input  logic i_ref_ready,
    input  logic i_done
);

    // high from done (or reset) until the next start
    logic waiting;
    // high from reset until the first start
    logic fresh;

    // number of failed assertions
    int fail_cnt = 0;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            waiting <= 1'b1;
            fresh   <= 1'b1;
        end else if (i_start) begin
            waiting <= 1'b0;
            fresh   <= 1'b0;
        end else if (i_done) begin
            waiting <= 1'b1;
        end
    end

    // the base that carries last ends the stream
    a_ready_low_after_last: assert property (
        @(posedge i_clk) disable iff (i_rst) (i_shift && i_ref_last) |=> !i_ref_ready
    ) else begin
        $error("ready still high after the last base was accepted");
        fail_cnt++;
    end

    a_done_one_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst) i_done |=> !i_done
    ) else begin
        $error("done held for more than one cycle");
        fail_cnt++;
    end

    a_ready_low_after_done: assert property (
        @(posedge i_clk) disable iff (i_rst) (waiting || i_done) |-> !i_ref_ready
    ) else begin
        $error("ready high between done and the next start");
        fail_cnt++;
    end

    a_quiet_after_reset: assert property (
        @(posedge i_clk) disable iff (i_rst) fresh |-> (!i_done && !i_ref_ready)
    ) else begin
        $error("done or ready active before the first start");
        fail_cnt++;
    end

endmodule

bind sw_aligner_top sw_aligner_chk u_chk (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (i_start),
    .i_shift     (shift),
    .i_ref_last  (i_ref_last),
    .i_ref_ready (o_ref_ready),
    .i_done      (o_done)
);

//--- tb_sw_aligner.sv
`timescale 1ns/1ps
`include "sw_config.svh"

module tb_sw_aligner
    import sw_score_pkg::*;
    import sw_ctrl_pkg::*;
();

    localparam int N       = `SW_N_PE;
    localparam int MAX_REF = 64;
    localparam int TMO     = 200;

    logic          clk;
    logic          rst;
    logic          start;
    base_t [N-1:0] query;
    logic          ref_valid;
    base_t         ref_base;
    logic          ref_last;
    logic          ready;
    logic          done;
    align_result_t result;

    align_result_t exp_result;
    int            exp_cnt;
    int            mon_err;
    int            mon_chk;
    int            tb_err;
    integer        seed;

    base_t ref_seq [0:MAX_REF-1];
    // transfer cycle of each base, counted from the first offer
    int    slot    [0:MAX_REF-1];

    sw_aligner_top i_dut (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_start     (start),
        .i_query     (query),
        .i_ref_valid (ref_valid),
        .i_ref_base  (ref_base),
        .i_ref_last  (ref_last),
        .o_ref_ready (ready),
        .o_done      (done),
        .o_result    (result)
    );

    sw_monitor u_mon (
        .i_clk     (clk),
        .i_done    (done),
        .i_result  (result),
        .i_exp     (exp_result),
        .i_exp_cnt (exp_cnt),
        .o_err_cnt (mon_err),
        .o_chk_cnt (mon_chk)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // full Gotoh matrix, then cells visited in the order the array shows them
    function automatic align_result_t ref_align(input base_t [N-1:0] q, input int len,
                                                input bit xdrop, output bit stopped);
        int hm [0:N-1][0:MAX_REF-1];
        int em [0:N-1][0:MAX_REF-1];
        int fm [0:N-1][0:MAX_REF-1];
        int hu, fu, hl, el, dg, h, best, wmax, wk, wj, cnt, kk;
        bit any;
        align_result_t r;
        for (int j = 0; j < len; j++) begin
            for (int k = 0; k < N; k++) begin
                hu = (k > 0) ? hm[k-1][j] : 0;
                fu = (k > 0) ? fm[k-1][j] : 0;
                hl = (j > 0) ? hm[k][j-1] : 0;
                el = (j > 0) ? em[k][j-1] : 0;
                dg = (k > 0 && j > 0) ? hm[k-1][j-1] : 0;
                em[k][j] = (hl - `SW_GAP_OPEN > el - `SW_GAP_EXT) ?
                           hl - `SW_GAP_OPEN : el - `SW_GAP_EXT;
                fm[k][j] = (hu - `SW_GAP_OPEN > fu - `SW_GAP_EXT) ?
                           hu - `SW_GAP_OPEN : fu - `SW_GAP_EXT;
                h = dg + ((q[k] == ref_seq[j]) ? `SW_MATCH : -`SW_MISMATCH);
                if (h < 0) h = 0;
                if (em[k][j] > h) h = em[k][j];
                if (fm[k][j] > h) h = fm[k][j];
                hm[k][j] = h;
            end
        end
        best    = 0;
        r       = '0;
        stopped = 1'b0;
        for (int c = 0; c <= slot[len-1] + N - 1 && !stopped; c++) begin
            any  = 1'b0;
            wmax = 0;
            wk   = N;
            wj   = 0;
            cnt  = 0;
            for (int j = 0; j < len; j++) begin
                if (slot[j] <= c) cnt++;
                kk = c - slot[j];
                if (kk >= 0 && kk < N) begin
                    // lower PE index keeps a tie
                    if (!any || hm[kk][j] > wmax || (hm[kk][j] == wmax && kk < wk)) begin
                        wmax = hm[kk][j];
                        wk   = kk;
                        wj   = j;
                    end
                    any = 1'b1;
                end
            end
            if (any && xdrop && cnt >= N && wmax + `SW_XDROP < best) begin
                stopped = 1'b1;
            end else if (any && wmax > best) begin
                best      = wmax;
                r.score   = score_t'(wmax);
                r.ref_pos = wj;
                r.qry_pos = qidx_t'(wk);
            end
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: monitor=%0d testbench=%0d assertions=%0d checks=%0d",
                 mon_err, tb_err, i_dut.u_chk.fail_cnt, mon_chk);
        $display("TEST FAIL");
        $finish;
    endtask

    // one alignment; returns the expected result that was posted
    task automatic align_once(input base_t [N-1:0] q, input int len, input bit gaps,
                              output align_result_t exp_r);
        int t;
        int j;
        int n;
        bit stop_exp;
        bit halted;
        t = 0;
        for (int i = 0; i < len; i++) begin
            if (gaps) begin
                while (($random(seed) & 3) == 0) t++;
            end
            slot[i] = t;
            t++;
        end
        exp_r      = ref_align(q, len, 1'b1, stop_exp);
        exp_result = exp_r;
        exp_cnt    = exp_cnt + 1;

        @(negedge clk);
        start = 1'b1;
        query = q;
        @(negedge clk);
        start = 1'b0;
        n = 0;
        while (!ready && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!ready) abort_run("ready never rose after start");

        t      = 0;
        j      = 0;
        halted = 1'b0;
        while (j < len && !halted) begin
            if (slot[j] == t) begin
                if (!ready) begin
                    // stopped early, stop offering bases
                    halted = 1'b1;
                end else begin
                    ref_valid = 1'b1;
                    ref_base  = ref_seq[j];
                    ref_last  = (j == len - 1);
                    j++;
                end
            end else begin
                ref_valid = 1'b0;
            end
            if (!halted) begin
                @(negedge clk);
                t++;
            end
        end
        ref_valid = 1'b0;
        ref_last  = 1'b0;
        if (halted != stop_exp) begin
            $display("early stop at %0t: expected %0d observed %0d", $time, stop_exp, halted);
            tb_err++;
        end

        n = 0;
        while (!done && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!done) abort_run("done never arrived after the reference stream");
        @(negedge clk);
    endtask

    initial begin
        base_t [N-1:0] q;
        align_result_t r1;
        align_result_t r2;
        int len;
        seed       = 32'ha9ce17f0;
        rst        = 1'b1;
        start      = 1'b0;
        query      = '0;
        ref_valid  = 1'b0;
        ref_base   = '0;
        ref_last   = 1'b0;
        exp_result = '0;
        exp_cnt    = 0;
        tb_err     = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // exact copy of a reference stretch
        for (int j = 0; j < 40; j++) ref_seq[j] = base_t'($random(seed));
        for (int k = 0; k < N; k++) q[k] = ref_seq[10 + k];
        align_once(q, 40, 1'b0, r1);
        if (r1.score != `SW_MATCH * N || r1.ref_pos != 10 + N - 1 || r1.qry_pos != N - 1) begin
            $display("model disagrees with the exact-match score or position");
            tb_err++;
        end

        // random pairs, gapless then with bubbles
        for (int i = 0; i < 4; i++) begin
            len = 32 + ($random(seed) & 15);
            for (int j = 0; j < len; j++) ref_seq[j] = base_t'($random(seed));
            for (int k = 0; k < N; k++) q[k] = base_t'($random(seed));
            align_once(q, len, 1'b0, r1);
            align_once(q, len, 1'b1, r2);
            if (r1.score != r2.score) begin
                $display("bubbles changed the expected best score in pair %0d", i);
                tb_err++;
            end
        end

        // early match, then a tail that never matches the A/C query
        for (int k = 0; k < N; k++) q[k] = base_t'($random(seed) & 1);
        for (int j = 0; j < 60; j++) begin
            ref_seq[j] = (j < N) ? q[j] : base_t'(2 + ($random(seed) & 1));
        end
        // whether the stop fires depends on the configured costs
        align_once(q, 60, 1'b0, r1);

        // back to back, everything mismatches
        for (int k = 0; k < N; k++) q[k] = base_t'(0);
        for (int j = 0; j < 24; j++) ref_seq[j] = base_t'(1);
        align_once(q, 24, 1'b0, r1);
        if (r1.score != 0) begin
            $display("model gives a nonzero score for a fully mismatching pair");
            tb_err++;
        end

        repeat (4) @(negedge clk);
        if (mon_chk != exp_cnt) begin
            $display("only %0d of %0d expected results were checked", mon_chk, exp_cnt);
            tb_err++;
        end
        $display("errors: monitor=%0d testbench=%0d assertions=%0d checks=%0d",
                 mon_err, tb_err, i_dut.u_chk.fail_cnt, mon_chk);
        if (mon_err == 0 && tb_err == 0 && i_dut.u_chk.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+.
sw_score_pkg.sv
sw_ctrl_pkg.sv
sw_pe.sv
sw_pe_array.sv
sw_max_tree.sv
sw_align_ctrl.sv
sw_aligner_top.sv
sw_monitor.sv
sw_aligner_chk.sv
tb_sw_aligner.sv
